// File: verilog/memsys_config.svh
`ifndef MEMSYS_CONFIG_SVH
`define MEMSYS_CONFIG_SVH

// Data path and bus width
`define MEMSYS_XLEN       32      // Data and byte address width

// Number of handler peers sharing the RAM
`define MEMSYS_NUM_HARTS  2       // Arbiter supports 1 to 4

// RAM geometry and timing
`define MEMSYS_MEM_WORDS  256     // Depth in words
`define MEMSYS_RAM_WAIT   1       // Extra cycles before pready

`endif

// File: verilog/memsys_pkg.sv
`include "memsys_config.svh"

package memsys_pkg;

    typedef logic [`MEMSYS_XLEN-1:0] word_t;    // One data word
    typedef logic [`MEMSYS_XLEN-1:0] addr_t;    // Byte address
    typedef logic [1:0]              hartId_t;  // Hart index, up to 4 harts

    // Memory operation codes, same encoding as the CPU control unit
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,   // Load byte, signed
        LH   = 4'd2,   // Load half, signed
        LW   = 4'd3,
        LBU  = 4'd4,
        LHU  = 4'd5,
        SB   = 4'd6,   // Store byte
        SH   = 4'd7,
        SW   = 4'd8
    } memOp_t;

    typedef enum logic [1:0] {
        FETCH  = 2'd0,  // Issue instruction fetch
        F_WAIT = 2'd1,  // Wait for fetch to finish
        DATA   = 2'd2,  // Issue load or store
        D_WAIT = 2'd3   // Wait for data access
    } handlerState_t;

    typedef struct packed {
        memOp_t    memOp;
        logic      memWrite;    // Store instruction
        logic      memRead;     // Load instruction
        logic      memSource;   // 1 selects FPU data for stores
        addr_t     aluAddress;  // Effective address from the ALU
        word_t     fpuData;
        word_t     regData;
    } cpuMemCtrl_t;

    typedef struct packed {
        logic      valid;       // One-cycle request pulse
        logic      write;
        addr_t     addr;
        word_t     wdata;
    } memReq_t;

    typedef struct packed {
        logic      busy;        // High while the request is outstanding
        word_t     rdata;       // Read word, valid once busy falls
    } memRsp_t;

endpackage

// File: verilog/memoryHandler.sv
`timescale 1ns/1ps
`include "memsys_config.svh"

module memoryHandler (
    input  logic                      clk,
    input  logic                      nrst,
    input  memsys_pkg::cpuMemCtrl_t   ctrl,        // Operation and operands from the CPU
    input  memsys_pkg::addr_t         pc,          // Fetch address
    input  memsys_pkg::memRsp_t       rsp,         // Busy and read word from the arbiter
    output memsys_pkg::memReq_t       req,         // Request pulse to the arbiter
    output memsys_pkg::word_t         instr,       // Last fetched instruction
    output logic                      instrValid,  // One cycle after fetch completes
    output memsys_pkg::word_t         dataToCPU,   // Extended load result
    output logic                      loadValid,   // One cycle after a load completes
    output logic                      freeze,      // Stalls the CPU while waiting
    output memsys_pkg::handlerState_t state
);

    memsys_pkg::handlerState_t stateNext;
    logic                      prevBusy;    // Busy seen last cycle
    logic                      busyEdge;    // Access just completed
    memsys_pkg::memOp_t        opReg;       // Operation captured in DATA
    logic                      readReg;     // Pending access is a load
    memsys_pkg::word_t         storeSrc;
    memsys_pkg::word_t         storeData;

    // Narrow stores write the whole word, zero-extended
    function automatic memsys_pkg::word_t formatStore(
        input memsys_pkg::memOp_t op,
        input memsys_pkg::word_t  src
    );
        case (op)
            memsys_pkg::SB: return {{(`MEMSYS_XLEN-8){1'b0}}, src[7:0]};
            memsys_pkg::SH: return {{(`MEMSYS_XLEN-16){1'b0}}, src[15:0]};
            memsys_pkg::SW: return src;
            default:        return '0;                  // Not a store
        endcase
    endfunction

    function automatic memsys_pkg::word_t extendLoad(
        input memsys_pkg::memOp_t op,
        input memsys_pkg::word_t  raw
    );
        case (op)
            memsys_pkg::LB:  return {{(`MEMSYS_XLEN-8){raw[7]}}, raw[7:0]};     // Sign extend byte
            memsys_pkg::LH:  return {{(`MEMSYS_XLEN-16){raw[15]}}, raw[15:0]};  // Sign extend half
            memsys_pkg::LBU: return {{(`MEMSYS_XLEN-8){1'b0}}, raw[7:0]};
            memsys_pkg::LHU: return {{(`MEMSYS_XLEN-16){1'b0}}, raw[15:0]};
            memsys_pkg::LW:  return raw;
            default:         return '0;
        endcase
    endfunction

    assign busyEdge = prevBusy && !rsp.busy;                      // Falling edge of busy
    assign storeSrc = ctrl.memSource ? ctrl.fpuData : ctrl.regData; // FPU or register file
    assign storeData = formatStore(ctrl.memOp, storeSrc);
    assign freeze = (state == memsys_pkg::F_WAIT) || (state == memsys_pkg::D_WAIT);

    // Next state and request pulse
    always_comb begin
        stateNext = state;
        req = '0;
        case (state)
            memsys_pkg::FETCH: begin
                req.valid = 1'b1;                     // Fetch read at pc
                req.addr = pc;
                stateNext = memsys_pkg::F_WAIT;
            end
            memsys_pkg::F_WAIT: begin
                if (busyEdge) begin
                    stateNext = memsys_pkg::DATA;     // Instruction is back
                end
            end
            memsys_pkg::DATA: begin
                if (ctrl.memWrite || ctrl.memRead) begin
                    req.valid = 1'b1;
                    req.write = ctrl.memWrite;        // Store wins if both set
                    req.addr = ctrl.aluAddress;
                    req.wdata = ctrl.memWrite ? storeData : '0;
                    stateNext = memsys_pkg::D_WAIT;
                end else begin
                    stateNext = memsys_pkg::FETCH;    // No memory operation
                end
            end
            memsys_pkg::D_WAIT: begin
                if (busyEdge) begin
                    stateNext = memsys_pkg::FETCH;
                end
            end
            default: stateNext = memsys_pkg::FETCH;
        endcase
    end

    // Control registers
    always_ff @(posedge clk) begin
        if (!nrst) begin
            prevBusy <= 1'b0;
            state <= memsys_pkg::FETCH;
            instrValid <= 1'b0;
            loadValid <= 1'b0;
            readReg <= 1'b0;
        end else begin
            prevBusy <= rsp.busy;
            state <= stateNext;
            instrValid <= (state == memsys_pkg::F_WAIT) && busyEdge;
            loadValid <= (state == memsys_pkg::D_WAIT) && busyEdge && readReg;
            if (state == memsys_pkg::DATA) begin
                readReg <= ctrl.memRead && !ctrl.memWrite;  // Loads return data
            end
        end
    end

    // Instruction, load result and captured operation
    always_ff @(posedge clk) begin
        if ((state == memsys_pkg::F_WAIT) && busyEdge) begin
            instr <= rsp.rdata;
        end
        if ((state == memsys_pkg::D_WAIT) && busyEdge && readReg) begin
            dataToCPU <= extendLoad(opReg, rsp.rdata);
        end
        if (state == memsys_pkg::DATA) begin
            opReg <= ctrl.memOp;                      // CPU inputs may change after DATA
        end
    end

endmodule

// File: verilog/busArbiter.sv
`timescale 1ns/1ps
`include "memsys_config.svh"

module busArbiter #(
    parameter int NUM_HARTS = `MEMSYS_NUM_HARTS
) (
    input  logic                clk,
    input  logic                nrst,
    input  memsys_pkg::memReq_t req [NUM_HARTS],  // Request pulses from the handlers
    input  memsys_pkg::word_t   prdata,
    input  logic                pready,
    output memsys_pkg::memRsp_t rsp [NUM_HARTS],  // Busy and read word per hart
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output memsys_pkg::addr_t   paddr,
    output memsys_pkg::word_t   pwdata
);

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SETUP  = 2'd1,   // psel only
        ACCESS = 2'd2    // psel and penable until pready
    } apbState_t;

    apbState_t            apbState;
    logic [NUM_HARTS-1:0] pendValid;             // Slot holds an outstanding request
    memsys_pkg::memReq_t  slot [NUM_HARTS];      // Pending request per hart
    memsys_pkg::word_t    rdataReg [NUM_HARTS];  // Read word returned per hart
    memsys_pkg::hartId_t  owner;                 // Current or last winner
    memsys_pkg::hartId_t  pick;
    logic                 found;
    memsys_pkg::memReq_t  cur;                   // Request on the bus
    logic                 done;

    assign done = (apbState == ACCESS) && pready;  // APB completion

    // Round robin, search above the last winner first, then wrap
    always_comb begin
        found = 1'b0;
        pick = owner;
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (!found && pendValid[h] && (memsys_pkg::hartId_t'(h) > owner)) begin
                found = 1'b1;
                pick = memsys_pkg::hartId_t'(h);
            end
        end
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (!found && pendValid[h] && (memsys_pkg::hartId_t'(h) <= owner)) begin
                found = 1'b1;
                pick = memsys_pkg::hartId_t'(h);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            apbState <= IDLE;
            pendValid <= '0;
            owner <= memsys_pkg::hartId_t'(NUM_HARTS - 1);  // Hart 0 wins first
        end else begin
            case (apbState)
                IDLE: begin
                    if (found) begin
                        apbState <= SETUP;
                        owner <= pick;
                    end
                end
                SETUP:   apbState <= ACCESS;
                ACCESS:  apbState <= pready ? IDLE : ACCESS;
                default: apbState <= IDLE;
            endcase
            for (int h = 0; h < NUM_HARTS; h++) begin
                if (done && (owner == memsys_pkg::hartId_t'(h))) begin
                    pendValid[h] <= 1'b0;           // Busy falls next cycle
                end
                if (req[h].valid) begin
                    pendValid[h] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (req[h].valid) begin
                slot[h] <= req[h];
            end
            if (done && (owner == memsys_pkg::hartId_t'(h))) begin
                rdataReg[h] <= prdata;              // Held until the next completion
            end
        end
    end

    always_comb begin
        cur = '0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (owner == memsys_pkg::hartId_t'(h)) begin
                cur = slot[h];
            end
        end
        for (int h = 0; h < NUM_HARTS; h++) begin
            rsp[h].busy = pendValid[h];
            rsp[h].rdata = rdataReg[h];
        end
    end

    assign psel = (apbState != IDLE);
    assign penable = (apbState == ACCESS);
    assign pwrite = cur.write;
    assign paddr = cur.addr;
    assign pwdata = cur.wdata;

endmodule

// File: verilog/apbRam.sv
`timescale 1ns/1ps
`include "memsys_config.svh"

module apbRam #(
    parameter int DEPTH = `MEMSYS_MEM_WORDS,  // Words
    parameter int WAIT  = `MEMSYS_RAM_WAIT    // Wait states per access
) (
    input  logic              clk,
    input  logic              nrst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  memsys_pkg::addr_t paddr,
    input  memsys_pkg::word_t pwdata,
    output memsys_pkg::word_t prdata,
    output logic              pready
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(WAIT + 2);  // At least one bit

    memsys_pkg::word_t mem [DEPTH];           // Word storage
    logic [IDX_W-1:0]  wordIdx;
    logic [CNT_W-1:0]  waitCnt;               // Cycles spent in access phase
    logic              access;

    assign access = psel && penable;
    assign wordIdx = IDX_W'(paddr[`MEMSYS_XLEN-1:2] % DEPTH);  // Byte lanes ignored
    assign pready = access && (waitCnt == CNT_W'(WAIT));
    assign prdata = mem[wordIdx];

    // Wait state counter
    always_ff @(posedge clk) begin
        if (!nrst) begin
            waitCnt <= '0;
        end else if (pready) begin
            waitCnt <= '0;                    // Ready for the next transfer
        end else if (access) begin
            waitCnt <= waitCnt + CNT_W'(1);
        end
    end

    // Write on the completing cycle
    always_ff @(posedge clk) begin
        if (pready && pwrite) begin
            mem[wordIdx] <= pwdata;
        end
    end

endmodule

// File: verilog/memSubsystem.sv
`timescale 1ns/1ps
`include "memsys_config.svh"

module memSubsystem #(
    parameter int NUM_HARTS = `MEMSYS_NUM_HARTS
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  memsys_pkg::cpuMemCtrl_t   ctrl [NUM_HARTS],        // Per-hart CPU control
    input  memsys_pkg::addr_t         pc [NUM_HARTS],          // Per-hart fetch address
    output memsys_pkg::word_t         instr [NUM_HARTS],
    output logic [NUM_HARTS-1:0]      instrValid,
    output memsys_pkg::word_t         dataToCPU [NUM_HARTS],
    output logic [NUM_HARTS-1:0]      loadValid,
    output logic [NUM_HARTS-1:0]      freeze,
    output memsys_pkg::handlerState_t state [NUM_HARTS]
);

    memsys_pkg::memReq_t req [NUM_HARTS];   // Handler to arbiter
    memsys_pkg::memRsp_t rsp [NUM_HARTS];   // Arbiter to handler
    logic                psel;
    logic                penable;
    logic                pwrite;
    memsys_pkg::addr_t   paddr;
    memsys_pkg::word_t   pwdata;
    memsys_pkg::word_t   prdata;
    logic                pready;

    // One handler per hart
    for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
        memoryHandler i_handler (
            .clk        (clk),
            .nrst       (nrst),
            .ctrl       (ctrl[h]),
            .pc         (pc[h]),
            .rsp        (rsp[h]),
            .req        (req[h]),
            .instr      (instr[h]),
            .instrValid (instrValid[h]),
            .dataToCPU  (dataToCPU[h]),
            .loadValid  (loadValid[h]),
            .freeze     (freeze[h]),
            .state      (state[h])
        );
    end

    busArbiter #(
        .NUM_HARTS (NUM_HARTS)
    ) i_arbiter (
        .clk     (clk),
        .nrst    (nrst),
        .req     (req),
        .prdata  (prdata),
        .pready  (pready),
        .rsp     (rsp),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata)
    );

    apbRam i_ram (
        .clk     (clk),
        .nrst    (nrst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

// File: bench/memSubsystem_checker.sv
`timescale 1ns/1ps
`include "memsys_config.svh"

module memSubsystem_checker #(
    parameter int NUM_HARTS = `MEMSYS_NUM_HARTS,
    parameter int MAX_BUSY  = 10                  // Cycles one request may stay busy
) (
    input logic                clk,
    input logic                nrst,
    input logic                psel,
    input logic                penable,
    input logic                pwrite,
    input logic                pready,
    input memsys_pkg::addr_t   paddr,
    input memsys_pkg::word_t   pwdata,
    input memsys_pkg::memRsp_t rsp [NUM_HARTS]
);

    int   failCount = 0;                          // Read by the testbench at the end
    int   busyLen [NUM_HARTS];                    // Consecutive busy cycles per hart
    logic tooLong;

    always @(posedge clk) begin
        for (int h = 0; h < NUM_HARTS; h++) begin
            busyLen[h] <= (!nrst || !rsp[h].busy) ? 0 : busyLen[h] + 1;
        end
    end

    always_comb begin
        tooLong = 1'b0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            tooLong = tooLong || (busyLen[h] > MAX_BUSY);
        end
    end

    // Access phase only follows a setup cycle
    assert property (@(posedge clk) disable iff (!nrst) $rose(penable) |-> $past(psel && !penable))
        else begin
            $error("penable rose without a setup phase");
            failCount++;
        end

    // Address, direction and data hold while the RAM inserts wait states
    assert property (@(posedge clk) disable iff (!nrst)
        (penable && !pready) |=> (penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else begin
            $error("APB signals changed during a wait state");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (!nrst) !tooLong)
        else begin
            $error("busy held longer than %0d cycles", MAX_BUSY);
            failCount++;
        end

endmodule

bind busArbiter memSubsystem_checker #(.NUM_HARTS(NUM_HARTS)) i_checker (.*);

// File: bench/memSubsystem_monitor.sv
`timescale 1ns/1ps
`include "memsys_config.svh"

module memSubsystem_monitor #(
    parameter int NUM_HARTS = `MEMSYS_NUM_HARTS,
    parameter int MAX_WAIT  = 10                  // Stall bound per access
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      psel,
    input  logic                      done,       // Stimulus finished
    input  memsys_pkg::cpuMemCtrl_t   ctrl [NUM_HARTS],
    input  memsys_pkg::addr_t         pc [NUM_HARTS],
    input  memsys_pkg::word_t         instr [NUM_HARTS],
    input  logic [NUM_HARTS-1:0]      instrValid,
    input  memsys_pkg::word_t         dataToCPU [NUM_HARTS],
    input  logic [NUM_HARTS-1:0]      loadValid,
    input  logic [NUM_HARTS-1:0]      freeze,
    input  memsys_pkg::handlerState_t state [NUM_HARTS],
    output logic                      reportDone = 1'b0,
    output int                        errorCount = 0
);

    localparam int NTEST = 6;

    memsys_pkg::word_t            model [`MEMSYS_MEM_WORDS];  // Reference memory
    logic [`MEMSYS_MEM_WORDS-1:0] known = '0;                 // Word written at least once
    logic [`MEMSYS_MEM_WORDS-1:0] narrow = '0;                // Last store was SB or SH
    memsys_pkg::word_t            expLoad [NUM_HARTS];
    int                           loadTest [NUM_HARTS];
    logic [NUM_HARTS-1:0]         loadPend = '0;
    logic [NUM_HARTS-1:0]         firstSeen = '0;             // First fetch after reset
    logic [NUM_HARTS-1:0]         waitExp = '0;               // Access outstanding per hart
    int                           waitCnt [NUM_HARTS];
    int                           sinceReset = 0;
    logic                         resetSeen = 1'b0;
    int                           checks [NTEST] = '{default: 0};
    int                           errs [NTEST] = '{default: 0};
    string                        names [NTEST] = '{"reset", "fetch", "word store/load",
                                                    "narrow store", "load extension", "contention"};
    memsys_pkg::word_t            w;
    int                           idx;

    function automatic int wordOf(input memsys_pkg::addr_t a);
        return int'(a[`MEMSYS_XLEN-1:2] % `MEMSYS_MEM_WORDS);   // Byte offset ignored
    endfunction

    function automatic memsys_pkg::word_t expectLoad(input memsys_pkg::memOp_t op,
                                                     input memsys_pkg::word_t m);
        case (op)
            memsys_pkg::LB:  return 32'($signed(m[7:0]));
            memsys_pkg::LH:  return 32'($signed(m[15:0]));
            memsys_pkg::LBU: return 32'(m[7:0]);
            memsys_pkg::LHU: return 32'(m[15:0]);
            default:         return m;
        endcase
    endfunction

    task automatic compareValue(input int t, input string sig, input int h,
                                input memsys_pkg::word_t got, input memsys_pkg::word_t exp);
        checks[t]++;
        if (got !== exp) begin
            errs[t]++;
            $display("ERROR t=%0t hart%0d %s: got %h, expected %h", $time, h, sig, got, exp);
        end
    endtask

    task automatic reportProblem(input int t, input string msg);
        checks[t]++;
        errs[t]++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    task automatic printTest(input int t);
        $display("Test %s: %0d checks, %0d errors, %s", names[t], checks[t], errs[t],
                 (errs[t] == 0) ? "ok" : "failed");
    endtask

    always @(posedge clk) begin
        if (!nrst) begin
            resetSeen = 1'b0;
            loadPend = '0;
            waitExp = '0;
        end else begin
            if (!resetSeen) begin                 // Outputs still hold reset values
                resetSeen = 1'b1;
                sinceReset = 0;
                compareValue(0, "psel", 0, 32'(psel), '0);
                for (int h = 0; h < NUM_HARTS; h++) begin
                    compareValue(0, "freeze", h, 32'(freeze[h]), '0);
                    compareValue(0, "instrValid", h, 32'(instrValid[h]), '0);
                    compareValue(0, "loadValid", h, 32'(loadValid[h]), '0);
                    compareValue(0, "state", h, 32'(state[h]), 32'(memsys_pkg::FETCH));
                    waitCnt[h] = 0;
                end
            end
            sinceReset++;
            for (int h = 0; h < NUM_HARTS; h++) begin
                if ((state[h] == memsys_pkg::FETCH) || instrValid[h]) begin
                    compareValue(1, "freeze", h, 32'(freeze[h]), '0);  // Request or DATA cycle
                end else begin
                    compareValue(1, "freeze", h, 32'(freeze[h]), 32'(waitExp[h]));
                end
                if (state[h] == memsys_pkg::FETCH) begin
                    waitExp[h] = 1'b1;                                  // Fetch issued
                end else if (instrValid[h]) begin
                    waitExp[h] = ctrl[h].memWrite || ctrl[h].memRead;   // Data access issued
                end
                waitCnt[h] = freeze[h] ? waitCnt[h] + 1 : 0;
                if (waitCnt[h] == MAX_WAIT + 1) begin
                    reportProblem(5, $sformatf("hart%0d stalled over %0d cycles", h, MAX_WAIT));
                end
                if (instrValid[h]) begin
                    checks[5]++;                  // One more access retired
                    if (!firstSeen[h]) begin
                        firstSeen[h] = 1'b1;
                        checks[0]++;
                        if (sinceReset > MAX_WAIT + 2) begin
                            reportProblem(0, $sformatf("hart%0d first fetch too late", h));
                        end
                        if (&firstSeen) begin
                            printTest(0);
                        end
                    end
                    idx = wordOf(pc[h]);
                    if (known[idx]) begin
                        compareValue(1, "instr", h, instr[h], model[idx]);
                    end
                end
                if (loadValid[h]) begin
                    if (loadPend[h]) begin
                        compareValue(loadTest[h], "dataToCPU", h, dataToCPU[h], expLoad[h]);
                        loadPend[h] = 1'b0;
                    end else begin
                        reportProblem(4, $sformatf("hart%0d gave loadValid with no load", h));
                    end
                end
                if (state[h] == memsys_pkg::DATA) begin
                    idx = wordOf(ctrl[h].aluAddress);
                    w = ctrl[h].memSource ? ctrl[h].fpuData : ctrl[h].regData;
                    if (ctrl[h].memWrite) begin
                        model[idx] = (ctrl[h].memOp == memsys_pkg::SB) ? 32'(w[7:0]) :
                                     (ctrl[h].memOp == memsys_pkg::SH) ? 32'(w[15:0]) : w;
                        known[idx] = 1'b1;
                        narrow[idx] = (ctrl[h].memOp != memsys_pkg::SW);
                    end else if (ctrl[h].memRead && known[idx]) begin
                        expLoad[h] = expectLoad(ctrl[h].memOp, model[idx]);
                        loadTest[h] = (ctrl[h].memOp != memsys_pkg::LW) ? 4 :
                                      (narrow[idx] ? 3 : 2);
                        loadPend[h] = 1'b1;
                    end
                end
            end
        end
        if (done && !reportDone) begin
            for (int t = 1; t < NTEST; t++) begin
                printTest(t);
            end
            errorCount = errs.sum();
            $display("Totals: %0d checks, %0d errors", checks.sum(), errorCount);
            reportDone = 1'b1;
        end
    end

endmodule

// File: bench/memSubsystem_tb.sv
`timescale 1ns/1ps
`include "memsys_config.svh"

module memSubsystem_tb;

    localparam int NUM_HARTS  = `MEMSYS_NUM_HARTS;
    localparam int HALF_WORDS = `MEMSYS_MEM_WORDS / NUM_HARTS;  // Private region per hart
    localparam int IDX_BITS   = $clog2(HALF_WORDS);
    localparam int FILL       = HALF_WORDS;                     // Initial SW sweep
    localparam int RANDOM_OPS = 200;
    localparam int LAST       = FILL + RANDOM_OPS + 2;          // Last op has retired by then
    localparam int LIMIT      = 200000;

    logic                      clk;
    logic                      nrst = 1'b0;
    memsys_pkg::cpuMemCtrl_t   ctrl [NUM_HARTS] = '{default: '0};
    memsys_pkg::addr_t         pc [NUM_HARTS] = '{default: '0};
    memsys_pkg::word_t         instr [NUM_HARTS];
    logic [NUM_HARTS-1:0]      instrValid;
    memsys_pkg::word_t         dataToCPU [NUM_HARTS];
    logic [NUM_HARTS-1:0]      loadValid;
    logic [NUM_HARTS-1:0]      freeze;
    memsys_pkg::handlerState_t state [NUM_HARTS];
    logic [31:0]               lfsr = 32'h4050;
    int                        count [NUM_HARTS] = '{default: 0};  // Instructions fetched
    logic                      done = 1'b0;
    logic                      reportDone;
    int                        errorCount;
    int                        cycles = 0;
    logic                      timedOut = 1'b0;

    memSubsystem i_dut (.*);

    memSubsystem_monitor i_monitor (.psel(i_dut.psel), .*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic memsys_pkg::addr_t regionBase(input int h);
        return memsys_pkg::addr_t'(h * HALF_WORDS * 4);
    endfunction

    function automatic memsys_pkg::cpuMemCtrl_t nextCtrl(input int h, input int idx);
        memsys_pkg::cpuMemCtrl_t c;
        int                      op;
        int                      wordIdx;
        c = '0;
        if (idx >= FILL + RANDOM_OPS) begin
            return c;                             // Drain with no memory operation
        end
        op = (idx < FILL) ? 8 : int'(takeBits(4)) % 9;
        wordIdx = (idx < FILL) ? idx : int'(takeBits(IDX_BITS));
        c.memOp = memsys_pkg::memOp_t'(4'(op));
        c.memWrite = (op >= 6);
        c.memRead = (op >= 1) && (op <= 5);
        c.memSource = 1'(takeBits(1));
        c.fpuData = takeBits(32);
        c.regData = takeBits(32);
        c.aluAddress = regionBase(h) + memsys_pkg::addr_t'(wordIdx * 4) + takeBits(2);
        return c;
    endfunction

    function automatic logic allRetired();
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (count[h] < LAST) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // New CPU operands after each fetched instruction
    always @(posedge clk) begin
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (!nrst) begin
                pc[h] <= regionBase(h);
            end else if (instrValid[h]) begin
                ctrl[h] <= nextCtrl(h, count[h]);
                pc[h] <= regionBase(h) + memsys_pkg::addr_t'(takeBits(IDX_BITS) * 4);
                count[h] <= count[h] + 1;
            end
        end
    end

    initial begin
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        while (!allRetired() && cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!allRetired()) begin
            timedOut = 1'b1;
            $display("Timeout: harts stopped retiring instructions");
        end else begin
            done <= 1'b1;
            cycles = 0;
            while (!reportDone && cycles < 100) begin
                @(posedge clk);
                cycles++;
            end
            if (!reportDone) begin
                timedOut = 1'b1;
                $display("Timeout: monitor gave no report");
            end
        end
        if (i_dut.i_arbiter.i_checker.failCount != 0) begin
            $display("%0d assertion failures", i_dut.i_arbiter.i_checker.failCount);
        end
        if (!timedOut && errorCount == 0 && i_dut.i_arbiter.i_checker.failCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+verilog
verilog/memsys_pkg.sv
verilog/memoryHandler.sv
verilog/busArbiter.sv
verilog/apbRam.sv
verilog/memSubsystem.sv
bench/memSubsystem_checker.sv
bench/memSubsystem_monitor.sv
bench/memSubsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= memSubsystem_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
